/* Makefile */
VERILATOR ?= verilator
TOP       ?= mips_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_TEXT)'

clean:
	rm -rf $(BUILD_DIR)

/* filelist.f */
+incdir+verilog
verilog/mipsPkg.sv
verilog/fetchStage.sv
verilog/decoder.sv
verilog/regFile.sv
verilog/pipeReg.sv
verilog/hazardUnit.sv
verilog/executeStage.sv
verilog/memStage.sv
verilog/mips.sv
test/mips_chk.sv
test/mips_tb.sv

/* test/mips_chk.sv */
module mips_chk (
    input logic              clk,
    input logic              rstN,
    input logic [31:0]       imemAddr,
    input mipsPkg::regTraceT regTrace,
    input mipsPkg::memTraceT memTrace
);

    // Pipeline holds only nops while reset is low
    quietInReset: assert property (@(posedge clk)
        !rstN |-> !regTrace.valid && !memTrace.valid)
        else $error("trace strobe during reset");

    // A retired register write carries a defined destination and value
    regTraceKnown: assert property (@(posedge clk) disable iff (!rstN)
        regTrace.valid |-> !$isunknown({regTrace.pc, regTrace.regNum, regTrace.data}))
        else $error("register trace with unknown bits");

    fetchAligned: assert property (@(posedge clk) disable iff (!rstN)
        imemAddr[1:0] == 2'b00)
        else $error("fetch address not word aligned");

    storeAligned: assert property (@(posedge clk) disable iff (!rstN)
        memTrace.valid |-> memTrace.addr[1:0] == 2'b00)
        else $error("store address not word aligned");

endmodule

bind mips mips_chk mips_chk_i (.clk, .rstN, .imemAddr, .regTrace, .memTrace);

/* test/mips_tb.sv */
`include "mips_defines.svh"

module mips_tb;

    localparam int IMEM_WORDS = 256;
    localparam logic [31:0] BASE = `MIPS_RESET_PC;

    logic              clk;
    logic              rstN;
    logic [31:0]       imemAddr;
    logic [31:0]       imemData;
    logic [31:0]       imemOff;
    mipsPkg::regTraceT regTrace;
    mipsPkg::memTraceT memTrace;

    logic [31:0]       imem [IMEM_WORDS];
    logic [31:0]       prog [$];
    // Reference register file and data memory, updated in program order
    logic [31:0]       rm [32];
    logic [31:0]       dm [logic [31:0]];
    mipsPkg::regTraceT regQ [$];
    mipsPkg::regTraceT expReg [$];
    mipsPkg::memTraceT memQ [$];
    mipsPkg::memTraceT expMem [$];
    string             testName;
    logic [31:0]       lfsr = 32'd83634;
    int                budget = 16;
    int                cycles = 0;

    mips mips_i (.clk, .rstN, .imemAddr, .imemData, .regTrace, .memTrace);

    // Instruction memory answers in the same cycle, nop outside the program
    assign imemOff  = imemAddr - BASE;
    assign imemData = (imemOff < 32'(IMEM_WORDS * 4)) ? imem[imemOff[9:2]] : 32'h0;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Records are taken at the edge where the write really happens
    always @(posedge clk) begin
        if (rstN && regTrace.valid)
            regQ.push_back(regTrace);
        if (rstN && memTrace.valid)
            memQ.push_back(memTrace);
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > budget)
            failRun("Timeout: the processor did not reach the end of the program in time");
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1);
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsrBit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randomWord();
        logic [31:0] w;
        w = '0;
        for (int i = 0; i < 32; i++)
            w = {w[30:0], lfsrBit()};
        return w;
    endfunction

    function automatic logic [31:0] rFormat(input logic [4:0] rs, rt, rd, input logic [5:0] fn);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic logic [31:0] iFormat(input logic [5:0] op, input logic [4:0] rs, rt,
                                            input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] jFormat(input logic [31:0] target);
        return {`OP_JAL, target[27:2]};
    endfunction

    function automatic logic [31:0] nextPc();
        return BASE + 32'(4 * prog.size());
    endfunction

    task automatic append(input logic [31:0] word);
        prog.push_back(word);
    endtask

    task automatic expectWrite(input logic [31:0] pc, input logic [4:0] r,
                               input logic [31:0] value);
        if (r != 5'd0) begin
            expReg.push_back(mipsPkg::regTraceT'{valid: 1'b1, pc: pc, regNum: r, data: value});
            rm[r] = value;
        end
    endtask

    task automatic orImm(input logic [4:0] rt, rs, input logic [15:0] imm);
        logic [31:0] pc;
        pc = nextPc();
        append(iFormat(`OP_ORI, rs, rt, imm));
        expectWrite(pc, rt, rm[rs] | {16'h0, imm});
    endtask

    task automatic loadUpper(input logic [4:0] rt, input logic [15:0] imm);
        logic [31:0] pc;
        pc = nextPc();
        append(iFormat(`OP_LUI, 5'd0, rt, imm));
        expectWrite(pc, rt, {imm, 16'h0});
    endtask

    task automatic addRegs(input logic [4:0] rd, rs, rt);
        logic [31:0] pc;
        pc = nextPc();
        append(rFormat(rs, rt, rd, `FN_ADDU));
        expectWrite(pc, rd, rm[rs] + rm[rt]);
    endtask

    task automatic subRegs(input logic [4:0] rd, rs, rt);
        logic [31:0] pc;
        pc = nextPc();
        append(rFormat(rs, rt, rd, `FN_SUBU));
        expectWrite(pc, rd, rm[rs] - rm[rt]);
    endtask

    task automatic storeWord(input logic [4:0] rt, base, input logic [15:0] off);
        logic [31:0] pc;
        logic [31:0] addr;
        pc   = nextPc();
        addr = rm[base] + {{16{off[15]}}, off};
        append(iFormat(`OP_SW, base, rt, off));
        expMem.push_back(mipsPkg::memTraceT'{valid: 1'b1, pc: pc, addr: addr, data: rm[rt]});
        dm[addr] = rm[rt];
    endtask

    task automatic loadWord(input logic [4:0] rt, base, input logic [15:0] off);
        logic [31:0] pc;
        logic [31:0] addr;
        pc   = nextPc();
        addr = rm[base] + {{16{off[15]}}, off};
        append(iFormat(`OP_LW, base, rt, off));
        expectWrite(pc, rt, dm.exists(addr) ? dm[addr] : 32'h0);
    endtask

    // A fresh program starts from a cleared register file and data memory
    task automatic newProgram(input string name);
        testName = name;
        prog.delete();
        expReg.delete();
        expMem.delete();
        dm.delete();
        foreach (rm[i])
            rm[i] = 32'h0;
    endtask

    task automatic resetAndLoad();
        @(negedge clk);
        rstN = 1'b0;
        // Reset, the drain after the marker and some slack
        budget = budget + 4 * prog.size() + 32;
        regQ.delete();
        memQ.delete();
        foreach (imem[i])
            imem[i] = (i < prog.size()) ? prog[i] : 32'h0;
        repeat (16) @(negedge clk);
        rstN = 1'b1;
    endtask

    task automatic runToMarker();
        logic [31:0] endPc;
        endPc = BASE + 32'(4 * (prog.size() - 1));
        do begin
            @(negedge clk);
        end while (imemAddr !== endPc);
        repeat (8) @(negedge clk);
    endtask

    task automatic compareTrace();
        assert (regQ.size() == expReg.size())
            else failRun($sformatf("** Error %s: expected %0d register writes, actual %0d",
                                   testName, expReg.size(), regQ.size()));
        foreach (expReg[i]) begin
            assert (regQ[i] == expReg[i])
                else failRun($sformatf("** Error %s: write %0d expected pc=%h r%0d=%h, actual pc=%h r%0d=%h",
                                       testName, i, expReg[i].pc, expReg[i].regNum,
                                       expReg[i].data, regQ[i].pc, regQ[i].regNum,
                                       regQ[i].data));
        end
        assert (memQ.size() == expMem.size())
            else failRun($sformatf("** Error %s: expected %0d stores, actual %0d",
                                   testName, expMem.size(), memQ.size()));
        foreach (expMem[i]) begin
            assert (memQ[i] == expMem[i])
                else failRun($sformatf("** Error %s: store %0d expected pc=%h [%h]=%h, actual pc=%h [%h]=%h",
                                       testName, i, expMem[i].pc, expMem[i].addr,
                                       expMem[i].data, memQ[i].pc, memQ[i].addr,
                                       memQ[i].data));
        end
    endtask

    task automatic runAndCheck();
        // Marker nop closes the program
        append(32'h0);
        resetAndLoad();
        runToMarker();
        compareTrace();
    endtask

    task automatic forwardingChain();
        newProgram("forwarding");
        orImm(5'd1, 5'd0, 16'h1234);
        loadUpper(5'd2, 16'h8000);
        addRegs(5'd3, 5'd1, 5'd2);
        subRegs(5'd4, 5'd3, 5'd1);
        addRegs(5'd5, 5'd4, 5'd2);
        subRegs(5'd6, 5'd0, 5'd1);
        loadUpper(5'd7, 16'hffff);
        addRegs(5'd8, 5'd7, 5'd7);
        orImm(5'd9, 5'd8, 16'h00ff);
        addRegs(5'd10, 5'd1, 5'd3);
        subRegs(5'd11, 5'd10, 5'd9);
        runAndCheck();
    endtask

    task automatic loadStoreUse();
        newProgram("load store");
        orImm(5'd1, 5'd0, 16'h0040);
        orImm(5'd2, 5'd0, 16'hbeef);
        storeWord(5'd2, 5'd1, 16'h0000);
        loadWord(5'd3, 5'd1, 16'h0000);
        // Load-use stall
        addRegs(5'd4, 5'd3, 5'd3);
        storeWord(5'd4, 5'd1, 16'h0004);
        loadWord(5'd5, 5'd1, 16'h0004);
        // Store data straight from the load ahead of it
        storeWord(5'd5, 5'd1, 16'hfffc);
        loadWord(5'd6, 5'd0, 16'h003c);
        subRegs(5'd7, 5'd6, 5'd2);
        runAndCheck();
    endtask

    task automatic branchDelaySlot();
        newProgram("branch");
        orImm(5'd1, 5'd0, 16'h0005);
        orImm(5'd2, 5'd0, 16'h0005);
        append(iFormat(`OP_BEQ, 5'd1, 5'd2, 16'd2));
        orImm(5'd3, 5'd0, 16'h0011);
        // Jumped over, no model update
        append(iFormat(`OP_ORI, 5'd0, 5'd4, 16'h0022));
        orImm(5'd5, 5'd0, 16'h0033);
        orImm(5'd6, 5'd0, 16'h0007);
        append(iFormat(`OP_BEQ, 5'd6, 5'd1, 16'd2));
        orImm(5'd7, 5'd0, 16'h0044);
        orImm(5'd8, 5'd0, 16'h0055);
        runAndCheck();
    endtask

    task automatic jumpAndReturn();
        logic [31:0] jalPc;
        newProgram("jal jr");
        jalPc = BASE + 32'h4;
        append(iFormat(`OP_ORI, 5'd0, 5'd1, 16'h0001));
        append(jFormat(BASE + 32'h1c));
        append(iFormat(`OP_ORI, 5'd0, 5'd2, 16'h0002));
        append(iFormat(`OP_ORI, 5'd0, 5'd3, 16'h0003));
        append(rFormat(5'd31, 5'd1, 5'd4, `FN_ADDU));
        append(iFormat(`OP_BEQ, 5'd0, 5'd0, 16'd3));
        append(32'h0);
        // Subroutine, $31 still in flight when jr decodes
        append(rFormat(5'd31, 5'd0, 5'd0, `FN_JR));
        append(iFormat(`OP_ORI, 5'd0, 5'd5, 16'h0005));
        append(iFormat(`OP_ORI, 5'd0, 5'd6, 16'h0006));
        expectWrite(BASE, 5'd1, 32'h1);
        expectWrite(jalPc, 5'd31, jalPc + 32'd8);
        expectWrite(BASE + 32'h08, 5'd2, 32'h2);
        expectWrite(BASE + 32'h20, 5'd5, 32'h5);
        expectWrite(BASE + 32'h0c, 5'd3, 32'h3);
        expectWrite(BASE + 32'h10, 5'd4, rm[31] + rm[1]);
        expectWrite(BASE + 32'h24, 5'd6, 32'h6);
        runAndCheck();
    endtask

    task automatic randomArith();
        logic [31:0] a;
        logic [31:0] b;
        newProgram("random operands");
        for (int i = 0; i < 20; i++) begin
            a = randomWord();
            b = randomWord();
            loadUpper(5'd1, a[31:16]);
            orImm(5'd1, 5'd1, a[15:0]);
            loadUpper(5'd2, b[31:16]);
            orImm(5'd2, 5'd2, b[15:0]);
            addRegs(5'd3, 5'd1, 5'd2);
            subRegs(5'd4, 5'd1, 5'd2);
            subRegs(5'd0, 5'd3, 5'd4);
        end
        runAndCheck();
    endtask

    task automatic resetMidRun();
        newProgram("before reset");
        orImm(5'd5, 5'd0, 16'h1234);
        orImm(5'd6, 5'd0, 16'h0055);
        storeWord(5'd5, 5'd0, 16'h0000);
        repeat (20) append(32'h0);
        resetAndLoad();
        while (memQ.size() == 0)
            @(negedge clk);
        repeat (3) @(negedge clk);
        compareTrace();
        // Registers and data memory must come back cleared
        newProgram("after reset");
        storeWord(5'd5, 5'd0, 16'h0004);
        storeWord(5'd6, 5'd0, 16'h0008);
        loadWord(5'd7, 5'd0, 16'h0000);
        runAndCheck();
    endtask

    initial begin
        rstN = 1'b0;
        foreach (imem[i])
            imem[i] = 32'h0;
        forwardingChain();
        loadStoreUse();
        branchDelaySlot();
        jumpAndReturn();
        randomArith();
        resetMidRun();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* verilog/decoder.sv */
`include "mips_defines.svh"

module decoder (
    input  logic [31:0]   instr,
    output mipsPkg::ctrlT ctrl
);

    logic [5:0] op;
    logic [5:0] fn;

    assign op = instr[31:26];
    assign fn = instr[5:0];

    always_comb begin
        ctrl       = '0;
        ctrl.rs    = instr[25:21];
        ctrl.rt    = instr[20:16];
        ctrl.imm16 = instr[15:0];
        ctrl.index = instr[25:0];
        case (op)
            `OP_SPECIAL: begin
                case (fn)
                    `FN_ADDU, `FN_SUBU: begin
                        ctrl.dst      = instr[15:11];
                        ctrl.regWrite = 1'b1;
                        ctrl.aluOp    = (fn == `FN_ADDU) ? mipsPkg::ALU_ADD : mipsPkg::ALU_SUB;
                        ctrl.useRs    = 1'b1;
                        ctrl.useRt    = 1'b1;
                        ctrl.tNew     = 2'd1;
                    end
                    `FN_JR: begin
                        ctrl.isJr  = 1'b1;
                        ctrl.useRs = 1'b1;
                    end
                    // sll zero and anything else is a nop
                    default: ctrl = '0;
                endcase
            end
            `OP_ORI: begin
                ctrl.dst      = instr[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_OR;
                ctrl.aluImm   = 1'b1;
                ctrl.useRs    = 1'b1;
                ctrl.tNew     = 2'd1;
            end
            `OP_LUI: begin
                ctrl.dst      = instr[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = mipsPkg::ALU_LUI;
                ctrl.aluImm   = 1'b1;
                ctrl.tNew     = 2'd1;
            end
            `OP_LW: begin
                ctrl.dst      = instr[20:16];
                ctrl.regWrite = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluImm   = 1'b1;
                ctrl.resSrc   = mipsPkg::RES_MEM;
                ctrl.useRs    = 1'b1;
                ctrl.tNew     = 2'd2;
            end
            `OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.signExt  = 1'b1;
                ctrl.aluImm   = 1'b1;
                ctrl.useRs    = 1'b1;
                ctrl.useRt    = 1'b1;
            end
            `OP_BEQ: begin
                ctrl.isBeq   = 1'b1;
                ctrl.signExt = 1'b1;
                ctrl.useRs   = 1'b1;
                ctrl.useRt   = 1'b1;
            end
            `OP_JAL: begin
                // Link register is fixed at $31
                ctrl.dst      = 5'd31;
                ctrl.regWrite = 1'b1;
                ctrl.isJal    = 1'b1;
                ctrl.resSrc   = mipsPkg::RES_PC8;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

/* verilog/executeStage.sv */
module executeStage (
    input  mipsPkg::ctrlT ctrl,
    input  logic [31:0]   srcA,
    input  logic [31:0]   srcB,
    input  logic [31:0]   extImm,
    output logic [31:0]   result
);

    logic [31:0] opB;

    assign opB = ctrl.aluImm ? extImm : srcB;

    // addu and subu wrap, no overflow trap
    always_comb begin
        case (ctrl.aluOp)
            mipsPkg::ALU_ADD: result = srcA + opB;
            mipsPkg::ALU_SUB: result = srcA - opB;
            mipsPkg::ALU_OR:  result = srcA | opB;
            mipsPkg::ALU_LUI: result = {opB[15:0], 16'h0000};
            default:          result = srcA + opB;
        endcase
    end

endmodule

/* verilog/fetchStage.sv */
`include "mips_defines.svh"

module fetchStage (
    input  logic          clk,
    input  logic          rstN,
    input  logic          stall,
    input  mipsPkg::ctrlT decCtrl,
    input  logic [31:0]   decPc,
    input  logic [31:0]   rsValue,
    input  logic          branchTaken,
    output logic [31:0]   pc
);

    logic [31:0] nextPc;
    logic [31:0] slotPc;
    logic [31:0] branchOff;

    // Address of the delay slot, base for branch and jal targets
    assign slotPc    = decPc + 32'd4;
    assign branchOff = {{14{decCtrl.imm16[15]}}, decCtrl.imm16, 2'b00};

    always_comb begin
        if (branchTaken) begin
            nextPc = slotPc + branchOff;
        end else if (decCtrl.isJal) begin
            nextPc = {slotPc[31:28], decCtrl.index, 2'b00};
        end else if (decCtrl.isJr) begin
            nextPc = rsValue;
        end else begin
            nextPc = pc + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= `MIPS_RESET_PC;
        end else if (!stall) begin
            pc <= nextPc;
        end
    end

endmodule

/* verilog/hazardUnit.sv */
module hazardUnit (
    input  mipsPkg::ctrlT   dCtrl,
    input  mipsPkg::ctrlT   eCtrl,
    input  mipsPkg::ctrlT   mCtrl,
    input  mipsPkg::ctrlT   wCtrl,
    output logic            stall,
    output logic            flushE,
    output mipsPkg::fwdSelT fwdDRs,
    output mipsPkg::fwdSelT fwdDRt,
    output mipsPkg::fwdSelT fwdERs,
    output mipsPkg::fwdSelT fwdERt,
    output mipsPkg::fwdSelT fwdMRt
);

    logic [1:0] useRs;
    logic [1:0] useRt;
    logic       lateRs;
    logic       lateRt;

    // Nearest producer wins; an unready one leaves the old value, fixed later
    function automatic mipsPkg::fwdSelT pick(input logic [4:0] r, input mipsPkg::ctrlT e,
                                             input mipsPkg::ctrlT m, input mipsPkg::ctrlT w);
        if (r == 5'd0)
            return mipsPkg::FWD_REG;
        if (e.regWrite && e.dst == r)
            return (e.tNew == 2'd0) ? mipsPkg::FWD_E : mipsPkg::FWD_REG;
        if (m.regWrite && m.dst == r)
            return (m.tNew <= 2'd1) ? mipsPkg::FWD_M : mipsPkg::FWD_REG;
        if (w.regWrite && w.dst == r)
            return mipsPkg::FWD_W;
        return mipsPkg::FWD_REG;
    endfunction

    // True when the nearest producer of r is later than the use
    function automatic logic late(input logic [4:0] r, input logic [1:0] tUse,
                                  input mipsPkg::ctrlT e, input mipsPkg::ctrlT m);
        logic [1:0] mNew;
        mNew = (m.tNew == 2'd0) ? 2'd0 : m.tNew - 2'd1;
        if (r == 5'd0)
            return 1'b0;
        if (e.regWrite && e.dst == r)
            return e.tNew > tUse;
        if (m.regWrite && m.dst == r)
            return mNew > tUse;
        return 1'b0;
    endfunction

    // Cycles from decode until the operand is consumed
    assign useRs = (dCtrl.isBeq || dCtrl.isJr) ? 2'd0 : 2'd1;
    assign useRt = dCtrl.isBeq ? 2'd0 : (dCtrl.memWrite ? 2'd2 : 2'd1);

    assign lateRs = dCtrl.useRs && late(dCtrl.rs, useRs, eCtrl, mCtrl);
    assign lateRt = dCtrl.useRt && late(dCtrl.rt, useRt, eCtrl, mCtrl);

    assign stall  = lateRs || lateRt;
    assign flushE = stall;

    assign fwdDRs = pick(dCtrl.rs, eCtrl, mCtrl, wCtrl);
    assign fwdDRt = pick(dCtrl.rt, eCtrl, mCtrl, wCtrl);
    assign fwdERs = pick(eCtrl.rs, '0, mCtrl, wCtrl);
    assign fwdERt = pick(eCtrl.rt, '0, mCtrl, wCtrl);
    assign fwdMRt = pick(mCtrl.rt, '0, '0, wCtrl);

endmodule

/* verilog/memStage.sv */
`include "mips_defines.svh"

module memStage (
    input  logic              clk,
    input  logic              rstN,
    input  mipsPkg::ctrlT     mCtrl,
    input  mipsPkg::emPayT    mPay,
    input  logic [31:0]       storeData,
    output logic [31:0]       loadData,
    output logic [31:0]       mValue,
    input  mipsPkg::ctrlT     wCtrl,
    input  mipsPkg::mwPayT    wPay,
    output logic [31:0]       wbValue,
    output mipsPkg::regTraceT regTrace,
    output mipsPkg::memTraceT memTrace
);

    localparam int AW = $clog2(`MIPS_DM_WORDS);

    logic [31:0]   mem [`MIPS_DM_WORDS];
    logic [AW-1:0] wordIdx;

    assign wordIdx = mPay.aluRes[AW+1:2];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `MIPS_DM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (mCtrl.memWrite) begin
            mem[wordIdx] <= storeData;
        end
    end

    assign loadData = mem[wordIdx];

    // M-stage forward value, a load is never ready here
    assign mValue = (mCtrl.resSrc == mipsPkg::RES_PC8) ? mPay.pc + 32'd8 : mPay.aluRes;

    always_comb begin
        case (wCtrl.resSrc)
            mipsPkg::RES_MEM: wbValue = wPay.loadData;
            mipsPkg::RES_PC8: wbValue = wPay.pc + 32'd8;
            default:          wbValue = wPay.aluRes;
        endcase
    end

    // Writes to $0 are dropped from the trace
    assign regTrace.valid  = wCtrl.regWrite && (wCtrl.dst != 5'd0);
    assign regTrace.pc     = wPay.pc;
    assign regTrace.regNum = wCtrl.dst;
    assign regTrace.data   = wbValue;

    assign memTrace.valid = mCtrl.memWrite;
    assign memTrace.pc    = mPay.pc;
    assign memTrace.addr  = mPay.aluRes;
    assign memTrace.data  = storeData;

endmodule

/* verilog/mips.sv */
module mips (
    input  logic              clk,
    input  logic              rstN,
    output logic [31:0]       imemAddr,
    input  logic [31:0]       imemData,
    output mipsPkg::regTraceT regTrace,
    output mipsPkg::memTraceT memTrace
);

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
    } fdPayT;

    fdPayT           fdNext, dPay;
    mipsPkg::dePayT  deNext, ePay;
    mipsPkg::emPayT  emNext, mPay;
    mipsPkg::mwPayT  mwNext, wPay;
    mipsPkg::ctrlT   dCtrl, eCtrl, mCtrl, wCtrl;
    mipsPkg::fwdSelT fwdDRs, fwdDRt, fwdERs, fwdERt, fwdMRt;

    logic        stall, flushE, branchTaken;
    logic [31:0] pc, rd1, rd2, dRs, dRt, dImm;
    logic [31:0] eFwd, eRs, eRt, aluRes;
    logic [31:0] mRt, loadData, mValue, wbValue;

    function automatic logic [31:0] fwdMux(input mipsPkg::fwdSelT sel,
                                           input logic [31:0] regVal, input logic [31:0] eVal,
                                           input logic [31:0] mVal, input logic [31:0] wVal);
        case (sel)
            mipsPkg::FWD_E: return eVal;
            mipsPkg::FWD_M: return mVal;
            mipsPkg::FWD_W: return wVal;
            default:        return regVal;
        endcase
    endfunction

    // Fetch
    fetchStage fetch_i (.clk, .rstN, .stall, .decCtrl(dCtrl), .decPc(dPay.pc),
                        .rsValue(dRs), .branchTaken, .pc);
    assign imemAddr = pc;
    assign fdNext   = '{pc: pc, instr: imemData};
    pipeReg #(.payloadT(fdPayT)) fdReg_i (.clk, .rstN, .en(!stall), .clr(1'b0),
                                          .d(fdNext), .q(dPay));

    // Decode, branch compare and jump resolution
    decoder decD_i (.instr(dPay.instr), .ctrl(dCtrl));
    regFile regFile_i (.clk, .rstN, .ra1(dCtrl.rs), .ra2(dCtrl.rt), .rd1, .rd2,
                       .we(wCtrl.regWrite), .wa(wCtrl.dst), .wd(wbValue));

    // Only jal offers a value from execute
    assign eFwd = ePay.pc + 32'd8;
    assign dRs  = fwdMux(fwdDRs, rd1, eFwd, mValue, wbValue);
    assign dRt  = fwdMux(fwdDRt, rd2, eFwd, mValue, wbValue);
    assign dImm = dCtrl.signExt ? {{16{dCtrl.imm16[15]}}, dCtrl.imm16} : {16'h0, dCtrl.imm16};
    assign branchTaken = dCtrl.isBeq && (dRs == dRt);

    assign deNext = '{instr: dPay.instr, pc: dPay.pc, rsVal: dRs, rtVal: dRt, extImm: dImm};
    pipeReg #(.payloadT(mipsPkg::dePayT)) deReg_i (.clk, .rstN, .en(1'b1), .clr(flushE),
                                                   .d(deNext), .q(ePay));

    hazardUnit hazard_i (.dCtrl, .eCtrl, .mCtrl, .wCtrl, .stall, .flushE,
                         .fwdDRs, .fwdDRt, .fwdERs, .fwdERt, .fwdMRt);

    // Execute
    decoder decE_i (.instr(ePay.instr), .ctrl(eCtrl));
    assign eRs = fwdMux(fwdERs, ePay.rsVal, 32'd0, mValue, wbValue);
    assign eRt = fwdMux(fwdERt, ePay.rtVal, 32'd0, mValue, wbValue);
    executeStage execute_i (.ctrl(eCtrl), .srcA(eRs), .srcB(eRt), .extImm(ePay.extImm),
                            .result(aluRes));

    assign emNext = '{instr: ePay.instr, pc: ePay.pc, aluRes: aluRes, storeData: eRt};
    pipeReg #(.payloadT(mipsPkg::emPayT)) emReg_i (.clk, .rstN, .en(1'b1), .clr(1'b0),
                                                   .d(emNext), .q(mPay));

    // Memory and writeback
    decoder decM_i (.instr(mPay.instr), .ctrl(mCtrl));
    assign mRt = fwdMux(fwdMRt, mPay.storeData, 32'd0, 32'd0, wbValue);

    assign mwNext = '{instr: mPay.instr, pc: mPay.pc, aluRes: mPay.aluRes, loadData: loadData};
    pipeReg #(.payloadT(mipsPkg::mwPayT)) mwReg_i (.clk, .rstN, .en(1'b1), .clr(1'b0),
                                                   .d(mwNext), .q(wPay));

    decoder decW_i (.instr(wPay.instr), .ctrl(wCtrl));
    memStage mem_i (.clk, .rstN, .mCtrl, .mPay, .storeData(mRt), .loadData, .mValue,
                    .wCtrl, .wPay, .wbValue, .regTrace, .memTrace);

endmodule

/* verilog/mipsPkg.sv */
package mipsPkg;

    typedef enum logic [1:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_OR,
        ALU_LUI
    } aluOpT;

    // Source of the value written back
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC8
    } resSrcT;

    // Operand source picked by the forwarding logic
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_E,
        FWD_M,
        FWD_W
    } fwdSelT;

    // Decoded controls, rebuilt in every stage from the instruction word
    typedef struct packed {
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [15:0] imm16;
        logic [25:0] index;
        logic        signExt;
        aluOpT       aluOp;
        logic        aluImm;
        logic        regWrite;
        logic        memWrite;
        resSrcT      resSrc;
        logic        isBeq;
        logic        isJal;
        logic        isJr;
        logic        useRs;
        logic        useRt;
        // Cycles after execute until the result exists
        logic [1:0]  tNew;
    } ctrlT;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] rsVal;
        logic [31:0] rtVal;
        logic [31:0] extImm;
    } dePayT;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] aluRes;
        logic [31:0] storeData;
    } emPayT;

    typedef struct packed {
        logic [31:0] instr;
        logic [31:0] pc;
        logic [31:0] aluRes;
        logic [31:0] loadData;
    } mwPayT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [4:0]  regNum;
        logic [31:0] data;
    } regTraceT;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] data;
    } memTraceT;

endpackage

/* verilog/mips_defines.svh */
`ifndef MIPS_DEFINES_SVH
`define MIPS_DEFINES_SVH

// First fetch address after reset
`define MIPS_RESET_PC 32'h0000_3000

// Data memory depth in words
`define MIPS_DM_WORDS 1024

// Primary opcodes, instr[31:26]
`define OP_SPECIAL 6'b000000
`define OP_ORI     6'b001101
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011
`define OP_BEQ     6'b000100
`define OP_JAL     6'b000011

// Function codes for OP_SPECIAL, instr[5:0]
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_JR   6'b001000

`endif

/* verilog/pipeReg.sv */
module pipeReg #(
    parameter type payloadT = logic [31:0]
) (
    input  logic    clk,
    input  logic    rstN,
    input  logic    en,
    input  logic    clr,
    input  payloadT d,
    output payloadT q
);

    // All-zero payload decodes as a nop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            q <= '0;
        end else if (clr) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

/* verilog/regFile.sv */
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  ra1,
    input  logic [4:0]  ra2,
    output logic [31:0] rd1,
    output logic [31:0] rd2,
    input  logic        we,
    input  logic [4:0]  wa,
    input  logic [31:0] wd
);

    logic [31:0] regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is covered by W forwarding, no bypass here
    assign rd1 = (ra1 == 5'd0) ? 32'd0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? 32'd0 : regs[ra2];

endmodule
